/* hdl/s64_isa_pkg.sv */
`default_nettype none

package s64_isa_pkg;

    localparam int XLEN     = 64;
    localparam int NIBBLE   = 4;
    localparam int MAX_SLOT = 7;

    // slot opcodes, anything else runs as a nop.
    localparam logic [NIBBLE-1:0] OPC_NOP    = 4'h0;
    localparam logic [NIBBLE-1:0] OPC_LIT8   = 4'h1;
    localparam logic [NIBBLE-1:0] OPC_LIT16  = 4'h2;
    localparam logic [NIBBLE-1:0] OPC_LIT32  = 4'h3;
    localparam logic [NIBBLE-1:0] OPC_STORES = 4'h4;
    localparam logic [NIBBLE-1:0] OPC_INTOPS = 4'h5;
    localparam logic [NIBBLE-1:0] OPC_STKOPS = 4'h6;

    localparam logic [NIBBLE-1:0] N_SBM = 4'h0;
    localparam logic [NIBBLE-1:0] N_SHM = 4'h1;
    localparam logic [NIBBLE-1:0] N_SWM = 4'h2;
    localparam logic [NIBBLE-1:0] N_SDM = 4'h3;

    localparam logic [NIBBLE-1:0] N_ADD  = 4'h0;
    localparam logic [NIBBLE-1:0] N_SUB  = 4'h1;
    localparam logic [NIBBLE-1:0] N_SLL  = 4'h2;
    localparam logic [NIBBLE-1:0] N_SLT  = 4'h3;
    localparam logic [NIBBLE-1:0] N_SLTU = 4'h4;
    localparam logic [NIBBLE-1:0] N_SGE  = 4'h5;
    localparam logic [NIBBLE-1:0] N_SGEU = 4'h6;
    localparam logic [NIBBLE-1:0] N_SEQ  = 4'h7;
    localparam logic [NIBBLE-1:0] N_SNE  = 4'h8;
    localparam logic [NIBBLE-1:0] N_XOR  = 4'h9;
    localparam logic [NIBBLE-1:0] N_SRL  = 4'hA;
    localparam logic [NIBBLE-1:0] N_SRA  = 4'hB;
    localparam logic [NIBBLE-1:0] N_OR   = 4'hC;
    localparam logic [NIBBLE-1:0] N_AND  = 4'hD;
    localparam logic [NIBBLE-1:0] N_BIC  = 4'hE;

    localparam logic [NIBBLE-1:0] N_DROP = 4'h0;
    localparam logic [NIBBLE-1:0] N_DUP  = 4'h1;
    localparam logic [NIBBLE-1:0] N_OVER = 4'h2;
    localparam logic [NIBBLE-1:0] N_SWAP = 4'h3;
    localparam logic [NIBBLE-1:0] N_ROT  = 4'h4;

    localparam logic [3:0] SA_HOLD  = 4'h0;
    localparam logic [3:0] SA_LIT   = 4'h1;
    localparam logic [3:0] SA_BINOP = 4'h2;
    localparam logic [3:0] SA_POP2  = 4'h3;
    localparam logic [3:0] SA_DROP  = 4'h4;
    localparam logic [3:0] SA_DUP   = 4'h5;
    localparam logic [3:0] SA_OVER  = 4'h6;
    localparam logic [3:0] SA_SWAP  = 4'h7;
    localparam logic [3:0] SA_ROT   = 4'h8;

    localparam logic [1:0] SZ_BYTE   = 2'd0;
    localparam logic [1:0] SZ_HALF   = 2'd1;
    localparam logic [1:0] SZ_WORD   = 2'd2;
    localparam logic [1:0] SZ_DOUBLE = 2'd3;

    // slot 1 sits in bits 59:56, right below the count.
    typedef struct packed {
        logic [NIBBLE-1:0]       count;
        logic [1:15][NIBBLE-1:0] slot;
    } slot_view_t;

    typedef union packed {
        slot_view_t      slots;
        logic [XLEN-1:0] raw;
    } packet_u;

endpackage

`default_nettype wire

/* hdl/s64_bus_pkg.sv */
`default_nettype none

package s64_bus_pkg;

    // word address covers byte address bits 63:3.
    localparam int ADR_W = 61;
    localparam int LANES = 8;

    // byte address e000_0000_0000_0000.
    localparam logic [ADR_W-1:0] RESET_VECTOR = 61'h1C00_0000_0000_0000;

endpackage

`default_nettype wire

/* hdl/s64_sequencer.sv */
`default_nettype none

module s64_sequencer (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    dat_i,
    input  logic [5:0]                      shift_i,
    output logic                            fetch_o,
    output logic [s64_bus_pkg::ADR_W-1:0]   ptr_o,
    output logic [3:0]                      opcode_o,
    output logic [31:0]                     operand_o
);
    import s64_isa_pkg::*;
    import s64_bus_pkg::*;

    logic [3:0] t;
    packet_u    ir;
    packet_u    opr;

    // counts 0 and 1 carry no slots.
    assign fetch_o = (t == 4'd0) || (t >= ir.slots.count);

    // slots above 7 run as nop.
    always_comb begin
        opcode_o = OPC_NOP;
        if (!fetch_o && (t <= MAX_SLOT)) begin
            opcode_o = ir.slots.slot[t];
        end
    end

    assign operand_o = opr.raw[31:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            t     <= 4'd0;
            ptr_o <= RESET_VECTOR;
        end else if (fetch_o) begin
            t     <= 4'd1;
            ptr_o <= ptr_o + 1'b1;
        end else begin
            t <= t + 4'd1;
        end
    end

    // operands are consumed from bit 0 upward.
    always_ff @(posedge clk_i) begin
        if (fetch_o) begin
            ir  <= dat_i;
            opr <= dat_i;
        end else begin
            opr.raw <= opr.raw >> shift_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/s64_decoder.sv */
`default_nettype none

module s64_decoder (
    input  logic [3:0]                      opcode_i,
    input  logic [31:0]                     operand_i,
    output logic [3:0]                      action_o,
    output logic [s64_isa_pkg::XLEN-1:0]    lit_o,
    output logic [5:0]                      shift_o,
    output logic                            store_o,
    output logic [1:0]                      size_o,
    output logic [3:0]                      alu_op_o
);
    import s64_isa_pkg::*;

    logic [NIBBLE-1:0] sub;

    assign sub      = operand_i[NIBBLE-1:0];
    assign alu_op_o = sub;

    always_comb begin
        action_o = SA_HOLD;
        lit_o    = '0;
        shift_o  = 6'd0;
        store_o  = 1'b0;
        size_o   = SZ_DOUBLE;
        case (opcode_i)
            OPC_LIT8: begin
                action_o = SA_LIT;
                lit_o    = {{(XLEN-8){operand_i[7]}}, operand_i[7:0]};
                shift_o  = 6'd8;
            end
            OPC_LIT16: begin
                action_o = SA_LIT;
                lit_o    = {{(XLEN-16){operand_i[15]}}, operand_i[15:0]};
                shift_o  = 6'd16;
            end
            OPC_LIT32: begin
                action_o = SA_LIT;
                lit_o    = {{(XLEN-32){operand_i[31]}}, operand_i[31:0]};
                shift_o  = 6'd32;
            end
            OPC_STORES: begin
                shift_o = 6'd4;
                case (sub)
                    N_SBM:   size_o = SZ_BYTE;
                    N_SHM:   size_o = SZ_HALF;
                    N_SWM:   size_o = SZ_WORD;
                    default: size_o = SZ_DOUBLE;
                endcase
                // a store consumes both address and data.
                if (sub <= N_SDM) begin
                    store_o  = 1'b1;
                    action_o = SA_POP2;
                end
            end
            OPC_INTOPS: begin
                shift_o = 6'd4;
                if (sub <= N_BIC) begin
                    action_o = SA_BINOP;
                end
            end
            OPC_STKOPS: begin
                shift_o = 6'd4;
                case (sub)
                    N_DROP:  action_o = SA_DROP;
                    N_DUP:   action_o = SA_DUP;
                    N_OVER:  action_o = SA_OVER;
                    N_SWAP:  action_o = SA_SWAP;
                    N_ROT:   action_o = SA_ROT;
                    default: action_o = SA_HOLD;
                endcase
            end
            default: begin
                shift_o = 6'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/s64_operand_stack.sv */
`default_nettype none

module s64_operand_stack (
    input  logic                            clk_i,
    input  logic [3:0]                      action_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    lit_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    alu_i,
    output logic [s64_isa_pkg::XLEN-1:0]    x_o,
    output logic [s64_isa_pkg::XLEN-1:0]    y_o,
    output logic [s64_isa_pkg::XLEN-1:0]    z_o
);
    import s64_isa_pkg::*;

    logic [XLEN-1:0] nx, ny, nz;
    logic [XLEN-1:0] spill [0:3];
    logic            push, pop1, pop2;

    always_comb begin
        nz   = z_o;
        ny   = y_o;
        nx   = x_o;
        push = 1'b0;
        pop1 = 1'b0;
        pop2 = 1'b0;
        case (action_i)
            SA_LIT:   begin nz = lit_i; ny = z_o; nx = y_o; push = 1'b1; end
            SA_DUP:   begin nz = z_o; ny = z_o; nx = y_o; push = 1'b1; end
            SA_OVER:  begin nz = y_o; ny = z_o; nx = y_o; push = 1'b1; end
            SA_BINOP: begin nz = alu_i; ny = x_o; nx = spill[0]; pop1 = 1'b1; end
            SA_DROP:  begin nz = y_o; ny = x_o; nx = spill[0]; pop1 = 1'b1; end
            SA_POP2:  begin nz = x_o; ny = spill[0]; nx = spill[1]; pop2 = 1'b1; end
            SA_SWAP:  begin nz = y_o; ny = z_o; end
            SA_ROT:   begin nz = x_o; ny = z_o; nx = y_o; end
            default:  begin nz = z_o; end
        endcase
    end

    // the bottom entry repeats on underflow.
    always_ff @(posedge clk_i) begin
        z_o <= nz;
        y_o <= ny;
        x_o <= nx;
        if (push) begin
            spill[0] <= x_o;
            for (int i = 1; i < 4; i++) begin
                spill[i] <= spill[i-1];
            end
        end else if (pop1) begin
            for (int i = 0; i < 3; i++) begin
                spill[i] <= spill[i+1];
            end
        end else if (pop2) begin
            spill[0] <= spill[2];
            spill[1] <= spill[3];
            spill[2] <= spill[3];
        end
    end

endmodule

`default_nettype wire

/* hdl/s64_alu.sv */
`default_nettype none

module s64_alu (
    input  logic [3:0]                      op_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    a_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    b_i,
    output logic [s64_isa_pkg::XLEN-1:0]    result_o
);
    import s64_isa_pkg::*;

    logic [5:0] shamt;

    assign shamt = b_i[5:0];

    // a is second on stack, b is the top.
    always_comb begin
        case (op_i)
            N_ADD:   result_o = a_i + b_i;
            N_SUB:   result_o = a_i - b_i;
            N_SLL:   result_o = a_i << shamt;
            N_SLT:   result_o = XLEN'($signed(a_i) < $signed(b_i));
            N_SLTU:  result_o = XLEN'(a_i < b_i);
            N_SGE:   result_o = XLEN'($signed(a_i) >= $signed(b_i));
            N_SGEU:  result_o = XLEN'(a_i >= b_i);
            N_SEQ:   result_o = XLEN'(a_i == b_i);
            N_SNE:   result_o = XLEN'(a_i != b_i);
            N_XOR:   result_o = a_i ^ b_i;
            N_SRL:   result_o = a_i >> shamt;
            N_SRA:   result_o = $signed(a_i) >>> shamt;
            N_OR:    result_o = a_i | b_i;
            N_AND:   result_o = a_i & b_i;
            N_BIC:   result_o = a_i & ~b_i;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/s64_bus_master.sv */
`default_nettype none

module s64_bus_master (
    input  logic                            rst_i,
    input  logic                            fetch_i,
    input  logic [s64_bus_pkg::ADR_W-1:0]   ptr_i,
    input  logic                            store_i,
    input  logic [1:0]                      size_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    addr_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    data_i,
    output logic [s64_bus_pkg::ADR_W-1:0]   adr_o,
    output logic                            cyc_o,
    output logic                            stb_o,
    output logic                            we_o,
    output logic                            vpa_o,
    output logic [s64_bus_pkg::LANES-1:0]   sel_o,
    output logic [s64_isa_pkg::XLEN-1:0]    dat_o
);
    import s64_isa_pkg::*;
    import s64_bus_pkg::*;

    assign stb_o = cyc_o;

    always_comb begin
        adr_o = '0;
        cyc_o = 1'b0;
        we_o  = 1'b0;
        vpa_o = 1'b0;
        sel_o = '0;
        dat_o = '0;
        if (!rst_i && fetch_i) begin
            adr_o = ptr_i;
            cyc_o = 1'b1;
            vpa_o = 1'b1;
            sel_o = '1;
        end else if (!rst_i && store_i) begin
            adr_o = addr_i[XLEN-1:3];
            cyc_o = 1'b1;
            we_o  = 1'b1;
            // data is copied to every lane, sel_o picks the live ones.
            case (size_i)
                SZ_BYTE: begin
                    sel_o = LANES'(1) << addr_i[2:0];
                    dat_o = {LANES{data_i[7:0]}};
                end
                SZ_HALF: begin
                    sel_o = LANES'(3) << {addr_i[2:1], 1'b0};
                    dat_o = {(LANES/2){data_i[15:0]}};
                end
                SZ_WORD: begin
                    sel_o = LANES'(15) << {addr_i[2], 2'b00};
                    dat_o = {(LANES/4){data_i[31:0]}};
                end
                default: begin
                    sel_o = '1;
                    dat_o = data_i;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/s64_core.sv */
`default_nettype none

module s64_core (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [s64_isa_pkg::XLEN-1:0]    dat_i,
    output logic [s64_bus_pkg::ADR_W-1:0]   adr_o,
    output logic                            cyc_o,
    output logic                            stb_o,
    output logic                            we_o,
    output logic                            vpa_o,
    output logic [s64_bus_pkg::LANES-1:0]   sel_o,
    output logic [s64_isa_pkg::XLEN-1:0]    dat_o
);
    import s64_isa_pkg::*;
    import s64_bus_pkg::*;

    logic             fetch;
    logic [ADR_W-1:0] ptr;
    logic [3:0]       opcode;
    logic [31:0]      operand;
    logic [3:0]       action;
    logic [XLEN-1:0]  lit;
    logic [5:0]       shift;
    logic             store;
    logic [1:0]       size;
    logic [3:0]       alu_op;
    logic [XLEN-1:0]  y, z;
    logic [XLEN-1:0]  alu_result;

    s64_sequencer u_seq (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .dat_i     (dat_i),
        .shift_i   (shift),
        .fetch_o   (fetch),
        .ptr_o     (ptr),
        .opcode_o  (opcode),
        .operand_o (operand)
    );

    s64_decoder u_dec (
        .opcode_i  (opcode),
        .operand_i (operand),
        .action_o  (action),
        .lit_o     (lit),
        .shift_o   (shift),
        .store_o   (store),
        .size_o    (size),
        .alu_op_o  (alu_op)
    );

    s64_operand_stack u_stack (
        .clk_i    (clk_i),
        .action_i (action),
        .lit_i    (lit),
        .alu_i    (alu_result),
        .x_o      (),
        .y_o      (y),
        .z_o      (z)
    );

    s64_alu u_alu (
        .op_i     (alu_op),
        .a_i      (y),
        .b_i      (z),
        .result_o (alu_result)
    );

    // stores write y to byte address z.
    s64_bus_master u_bus (
        .rst_i   (rst_i),
        .fetch_i (fetch),
        .ptr_i   (ptr),
        .store_i (store),
        .size_i  (size),
        .addr_i  (z),
        .data_i  (y),
        .adr_o   (adr_o),
        .cyc_o   (cyc_o),
        .stb_o   (stb_o),
        .we_o    (we_o),
        .vpa_o   (vpa_o),
        .sel_o   (sel_o),
        .dat_o   (dat_o)
    );

endmodule

`default_nettype wire

/* sim/s64_core_sva.sv */
`default_nettype none

module s64_core_sva (
    input  logic clk_i,
    input  logic rst_i,
    input  logic cyc_i,
    input  logic stb_i,
    input  logic we_i,
    input  logic vpa_i
);

    int fail_count = 0;

    // the bus stays idle while reset is held.
    idle_in_reset: assert property (@(posedge clk_i) rst_i |-> !cyc_i)
        else begin
            fail_count++;
            $error("bus cycle started during reset");
        end

    strobe_follows_cycle: assert property (@(posedge clk_i) stb_i == cyc_i)
        else begin
            fail_count++;
            $error("stb differs from cyc");
        end

    // a fetch and a store never start in the same cycle.
    no_joint_rise: assert property (@(posedge clk_i) disable iff (rst_i)
        !($rose(we_i) && $rose(vpa_i)))
        else begin
            fail_count++;
            $error("we and vpa rose together");
        end

endmodule

bind s64_core s64_core_sva u_sva (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (cyc_o),
    .stb_i (stb_o),
    .we_i  (we_o),
    .vpa_i (vpa_o)
);

`default_nettype wire

/* sim/s64_core_tb.sv */
`default_nettype none

module s64_core_tb;
    import s64_isa_pkg::*;
    import s64_bus_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int EXP_W     = ADR_W + LANES + XLEN;

    logic             clk_i;
    logic             rst_i;
    logic [XLEN-1:0]  dat_i;
    logic [ADR_W-1:0] adr_o;
    logic             cyc_o;
    logic             stb_o;
    logic             we_o;
    logic             vpa_o;
    logic [LANES-1:0] sel_o;
    logic [XLEN-1:0]  dat_o;

    logic [XLEN-1:0]  mem [0:MEM_WORDS-1];
    int               n_words = 0;
    logic [ADR_W-1:0] fetch_idx;
    logic [XLEN-1:0]  pk = '0;
    int               pk_slots = 0;
    int               pk_bits = 0;
    logic [XLEN-1:0]  prev_top;
    logic [31:0]      lcg_state;

    // expected store as {word address, lane select, data}.
    logic [EXP_W-1:0] exp_q [$];
    logic [EXP_W-1:0] exp_store;
    logic [ADR_W-1:0] next_fetch;
    logic             seen_cycle;
    int               mismatches = 0;
    int               other_errors = 0;
    int               stores_checked = 0;

    s64_core UUT (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .dat_i (dat_i),
        .adr_o (adr_o),
        .cyc_o (cyc_o),
        .stb_o (stb_o),
        .we_o  (we_o),
        .vpa_o (vpa_o),
        .sel_o (sel_o),
        .dat_o (dat_o)
    );

    // words past the program read as zero-count packets.
    assign fetch_idx = adr_o - RESET_VECTOR;
    assign dat_i     = (fetch_idx < ADR_W'(n_words)) ? mem[fetch_idx] : '0;

    initial begin
        clk_i = 1'b0;
        forever begin
            #50;
            clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] sext(input logic [31:0] v, input int width);
        logic [XLEN-1:0] r;
        case (width)
            8:       r = {{56{v[7]}}, v[7:0]};
            16:      r = {{48{v[15]}}, v[15:0]};
            default: r = {{32{v[31]}}, v};
        endcase
        return r;
    endfunction

    function automatic logic [EXP_W-1:0] expect_store(
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b,
        input logic [XLEN-1:0] under,
        input logic [3:0]      op_opc,
        input logic [3:0]      sub,
        input logic [XLEN-1:0] addr,
        input logic [3:0]      size
    );
        logic [XLEN-1:0]  v;
        logic [LANES-1:0] sel;
        logic [XLEN-1:0]  dat;
        logic [2:0]       lo;
        if (op_opc == OPC_INTOPS) begin
            case (sub)
                N_ADD:   v = a + b;
                N_SUB:   v = a - b;
                N_SLL:   v = a << b[5:0];
                N_SLT:   v = {63'd0, $signed(a) < $signed(b)};
                N_SLTU:  v = {63'd0, a < b};
                N_SGE:   v = {63'd0, $signed(a) >= $signed(b)};
                N_SGEU:  v = {63'd0, a >= b};
                N_SEQ:   v = {63'd0, a == b};
                N_SNE:   v = {63'd0, a != b};
                N_XOR:   v = a ^ b;
                N_SRL:   v = a >> b[5:0];
                N_SRA:   v = $signed(a) >>> b[5:0];
                N_OR:    v = a | b;
                N_AND:   v = a & b;
                default: v = a & ~b;
            endcase
        end else begin
            // what sits under the address after the stack op, in Forth order.
            case (sub)
                N_DUP:   v = b;
                N_ROT:   v = under;
                default: v = a;
            endcase
        end
        lo = addr[2:0];
        case (size)
            N_SBM: begin
                sel = 8'b1 << lo;
                dat = {8{v[7:0]}};
            end
            N_SHM: begin
                sel = 8'b11 << (lo & 3'd6);
                dat = {4{v[15:0]}};
            end
            N_SWM: begin
                sel = lo[2] ? 8'hF0 : 8'h0F;
                dat = {2{v[31:0]}};
            end
            default: begin
                sel = 8'hFF;
                dat = v;
            end
        endcase
        return {addr[XLEN-1:3], sel, dat};
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        if (got !== want) begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    // slot 1 sits at 59:56 and operands fill from bit 0 upward.
    task automatic add_slot(input logic [3:0] opc, input logic [31:0] opnd, input int width);
        pk[59 - 4*pk_slots -: 4] = opc;
        pk = pk | ((XLEN'(opnd) & ((64'd1 << width) - 64'd1)) << pk_bits);
        pk_slots++;
        pk_bits += width;
    endtask

    task automatic flush_packet();
        pk[63:60] = 4'(pk_slots + 1);
        mem[n_words] = pk;
        n_words++;
        pk = '0;
        pk_slots = 0;
        pk_bits = 0;
    endtask

    task automatic add_case(input logic [3:0] lit_opc, input logic [31:0] a_bits,
                            input logic [7:0] b_bits, input logic [3:0] op_opc,
                            input logic [3:0] sub, input logic [7:0] addr_bits,
                            input logic [3:0] size);
        int              width;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        case (lit_opc)
            OPC_LIT16: width = 16;
            OPC_LIT32: width = 32;
            default:   width = 8;
        endcase
        a = sext(a_bits, width);
        b = sext({24'd0, b_bits}, 8);
        add_slot(lit_opc, a_bits, width);
        // a wide literal leaves too few operand bits, so it gets a packet of its own.
        if (width > 8) begin
            flush_packet();
        end
        add_slot(OPC_LIT8, {24'd0, b_bits}, 8);
        add_slot(op_opc, {28'd0, sub}, 4);
        add_slot(OPC_LIT8, {24'd0, addr_bits}, 8);
        add_slot(OPC_STORES, {28'd0, size}, 4);
        flush_packet();
        exp_q.push_back(expect_store(a, b, prev_top, op_opc, sub,
                                     sext({24'd0, addr_bits}, 8), size));
        // every stack case but drop leaves b on top.
        if (op_opc == OPC_STKOPS && sub != N_DROP) begin
            prev_top = b;
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  stk_seq [0:4] = '{N_DUP, N_OVER, N_SWAP, N_ROT, N_DROP};
        for (int round = 0; round < 2; round++) begin
            for (int op = 0; op <= 14; op++) begin
                r = lcg_next();
                add_case(OPC_LIT8, {24'd0, r[31:24]}, r[23:16], OPC_INTOPS, 4'(op),
                         r[15:8], N_SDM);
            end
        end
        // narrow stores at every byte offset.
        for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 8; off++) begin
                r = lcg_next();
                add_case(OPC_LIT8, {24'd0, r[31:24]}, r[23:16], OPC_INTOPS, N_SUB,
                         {r[15:11], 3'(off)}, 4'(sz));
            end
        end
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 5; k++) begin
                r = lcg_next();
                add_case(OPC_LIT8, {24'd0, r[31:24]}, r[23:16], OPC_STKOPS, stk_seq[k],
                         r[15:8], N_SDM);
            end
        end
        // wide literals with the sign bit set.
        for (int k = 0; k < 3; k++) begin
            r = lcg_next();
            s = lcg_next();
            add_case(OPC_LIT16, {16'd0, 1'b1, r[30:16]}, s[31:24], OPC_STKOPS, N_OVER,
                     s[23:16], N_SDM);
            add_case(OPC_LIT32, {1'b1, s[30:0]}, r[15:8], OPC_INTOPS, N_ADD,
                     r[7:0], N_SDM);
        end
    endtask

    task automatic finish_run();
        int total;
        total = mismatches + other_errors + UUT.u_sva.fail_count;
        $display("stores checked %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 stores_checked, mismatches, other_errors, UUT.u_sva.fail_count);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        rst_i      = 1'b1;
        lcg_state  = 32'd40;
        prev_top   = 'x;
        next_fetch = RESET_VECTOR;
        seen_cycle = 1'b0;
        build_program();
        repeat (10) @(posedge clk_i);
        #5;
        rst_i = 1'b0;
        wait (exp_q.size() == 0);
        repeat (4) @(posedge clk_i);
        finish_run();
    end

    // outputs are settled at the falling edge.
    always @(negedge clk_i) begin
        if (!rst_i && cyc_o) begin
            if (!seen_cycle) begin
                check_value("vpa_o", vpa_o, 1'b1);
                seen_cycle = 1'b1;
            end
            if (vpa_o) begin
                check_value("adr_o", adr_o, next_fetch);
                check_value("sel_o", sel_o, {LANES{1'b1}});
                next_fetch = next_fetch + 1'b1;
            end
            if (we_o) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("store to word address %h when no store was expected", adr_o);
                end else begin
                    exp_store = exp_q.pop_front();
                    stores_checked++;
                    check_value("adr_o", adr_o, exp_store[EXP_W-1:LANES+XLEN]);
                    check_value("sel_o", sel_o, exp_store[LANES+XLEN-1:XLEN]);
                    check_value("dat_o", dat_o, exp_store[XLEN-1:0]);
                end
            end
        end
    end

    initial begin
        @(negedge rst_i);
        repeat (n_words * 10) @(posedge clk_i);
        other_errors++;
        $display("timeout with %0d expected stores never seen", exp_q.size());
        finish_run();
    end

endmodule

`default_nettype wire

/* all.f */
hdl/s64_isa_pkg.sv
hdl/s64_bus_pkg.sv
hdl/s64_sequencer.sv
hdl/s64_decoder.sv
hdl/s64_operand_stack.sv
hdl/s64_alu.sv
hdl/s64_bus_master.sv
hdl/s64_core.sv
sim/s64_core_sva.sv
sim/s64_core_tb.sv

/* Bender.yml */
package:
  name: s64_core

sources:
  - files:
      - hdl/s64_isa_pkg.sv
      - hdl/s64_bus_pkg.sv
      - hdl/s64_sequencer.sv
      - hdl/s64_decoder.sv
      - hdl/s64_operand_stack.sv
      - hdl/s64_alu.sv
      - hdl/s64_bus_master.sv
      - hdl/s64_core.sv
  - target: simulation
    files:
      - sim/s64_core_sva.sv
      - sim/s64_core_tb.sv
